// File: hdl/blackjack_params.svh
`ifndef BLACKJACK_PARAMS_SVH
`define BLACKJACK_PARAMS_SVH

// card slots in each hand.
`define BJ_HAND_SLOTS 9

// dealer stops drawing at or above this total.
`define BJ_DEALER_STAND 17

// highest total that is not bust.
`define BJ_BUST_LIMIT 21

// nonzero start value of the shoe lfsr.
`define BJ_SHOE_SEED 16'hACE1

`endif

// File: hdl/blackjack_pkg.sv
`include "blackjack_params.svh"

package blackjack_pkg;

    // rank 0 is an empty slot, 1 is an ace, 11 to 13 are face cards.
    typedef logic [3:0] card_t;

    // slot 0 holds the first card dealt.
    typedef card_t [`BJ_HAND_SLOTS-1:0] hand_t;

    typedef logic [4:0] total_t;

    typedef logic [3:0] count_t;

    typedef enum logic [1:0] {
        none       = 2'd0,
        player_win = 2'd1,
        dealer_win = 2'd2,
        push       = 2'd3
    } outcome_t;

endpackage

// File: hdl/card_shoe.sv
`timescale 1ns/1ps

`include "blackjack_params.svh"

module card_shoe (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 draw,
    output logic                 card_valid,
    output blackjack_pkg::card_t card_rank
);

    logic [15:0] lfsr;
    logic [15:0] lfsr_next;
    logic        pending;
    logic        busy;
    logic        accept;

    // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1.
    assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);

    // the lfsr steps on the draw cycle and on every cycle after until a rank is taken.
    assign busy = draw || pending;

    // low nibble 0, 14 and 15 are thrown away.
    assign accept = busy && (lfsr_next[3:0] != 4'd0) && (lfsr_next[3:0] <= 4'd13);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr       <= `BJ_SHOE_SEED;
            pending    <= 1'b0;
            card_valid <= 1'b0;
        end else begin
            card_valid <= accept;
            pending    <= busy && !accept;
            if (busy) begin
                lfsr <= lfsr_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            card_rank <= lfsr_next[3:0];
        end
    end

endmodule

// File: hdl/hand_register.sv
`timescale 1ns/1ps

`include "blackjack_params.svh"

module hand_register (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  append,
    input  blackjack_pkg::card_t  card,
    output blackjack_pkg::hand_t  cards,
    output blackjack_pkg::count_t count
);

    logic full;

    assign full = (count >= `BJ_HAND_SLOTS);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // slot store
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // cards land in arrival order; zeroed slots score nothing.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cards <= '0;
            count <= '0;
        end else if (clear) begin
            cards <= '0;
            count <= '0;
        end else if (append && !full) begin
            cards[count] <= card;
            count        <= count + 4'd1;
        end
    end

endmodule

// File: hdl/calculate_card.sv
`timescale 1ns/1ps

`include "blackjack_params.svh"

module calculate_card (
    input  logic                  clk,
    input  logic                  rst,
    input  blackjack_pkg::hand_t  player_cards,
    input  blackjack_pkg::hand_t  dealer_cards,
    output blackjack_pkg::total_t total_players_value,
    output blackjack_pkg::total_t total_dealer_value
);

    blackjack_pkg::total_t player_nxt;
    blackjack_pkg::total_t dealer_nxt;

    // value one card adds on top of the total so far.
    function automatic blackjack_pkg::total_t card_value(
        input blackjack_pkg::card_t  card,
        input blackjack_pkg::total_t running
    );
        case (card)
            4'd0:               card_value = 5'd0;
            4'd1: begin
                // ace counts high only while that stays under the bust limit.
                if (running + 5'd11 <= `BJ_BUST_LIMIT) begin
                    card_value = 5'd11;
                end else begin
                    card_value = 5'd1;
                end
            end
            4'd11, 4'd12, 4'd13: card_value = 5'd10;
            default:            card_value = {1'b0, card};
        endcase
    endfunction

    // summed strictly in slot order.
    function automatic blackjack_pkg::total_t score_hand(input blackjack_pkg::hand_t hand);
        blackjack_pkg::total_t acc;
        acc = '0;
        for (int i = 0; i < `BJ_HAND_SLOTS; i++) begin
            acc = acc + card_value(hand[i], acc);
        end
        return acc;
    endfunction

    assign player_nxt = score_hand(player_cards);
    assign dealer_nxt = score_hand(dealer_cards);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            total_players_value <= '0;
            total_dealer_value  <= '0;
        end else begin
            total_players_value <= player_nxt;
            total_dealer_value  <= dealer_nxt;
        end
    end

endmodule

// File: hdl/game_controller.sv
`timescale 1ns/1ps

`include "blackjack_params.svh"

module game_controller (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     hit,
    input  logic                     stand,
    input  logic                     card_valid,
    input  blackjack_pkg::total_t    player_total,
    input  blackjack_pkg::total_t    dealer_total,
    input  blackjack_pkg::count_t    player_count,
    input  blackjack_pkg::count_t    dealer_count,
    output logic                     draw,
    output logic                     clear,
    output logic                     card_to_dealer,
    output logic                     player_turn,
    output logic                     done,
    output blackjack_pkg::outcome_t  outcome
);

    typedef enum logic [2:0] {
        s_idle,
        s_clear,
        s_deal,
        s_wait_card,
        s_settle,
        s_player,
        s_dealer,
        s_result
    } state_t;

    state_t                  state;
    logic [2:0]              deal_cnt;
    logic                    dealer_phase;
    logic                    settle_cnt;
    logic                    to_dealer;
    logic                    player_bust;
    logic                    dealer_bust;
    logic                    dealer_draws;
    blackjack_pkg::outcome_t verdict;

    assign player_bust  = (player_total > `BJ_BUST_LIMIT);
    assign dealer_bust  = (dealer_total > `BJ_BUST_LIMIT);
    assign dealer_draws = (dealer_total < `BJ_DEALER_STAND) && (dealer_count < `BJ_HAND_SLOTS);

    // a player bust wins for the dealer before the dealer's own total matters.
    always_comb begin
        if (player_bust) begin
            verdict = blackjack_pkg::dealer_win;
        end else if (dealer_bust) begin
            verdict = blackjack_pkg::player_win;
        end else if (player_total > dealer_total) begin
            verdict = blackjack_pkg::player_win;
        end else if (player_total < dealer_total) begin
            verdict = blackjack_pkg::dealer_win;
        end else begin
            verdict = blackjack_pkg::push;
        end
    end

    assign draw           = (state == s_deal);
    assign clear          = (state == s_clear);
    assign player_turn    = (state == s_player);
    assign card_to_dealer = to_dealer;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hand sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= s_idle;
            deal_cnt     <= '0;
            dealer_phase <= 1'b0;
            settle_cnt   <= 1'b0;
            to_dealer    <= 1'b0;
            done         <= 1'b0;
            outcome      <= blackjack_pkg::none;
        end else begin
            done <= 1'b0;
            case (state)
                s_idle: begin
                    if (start) begin
                        state        <= s_clear;
                        deal_cnt     <= '0;
                        dealer_phase <= 1'b0;
                        to_dealer    <= 1'b0;
                        outcome      <= blackjack_pkg::none;
                    end
                end
                s_clear: state <= s_deal;
                s_deal:  state <= s_wait_card;
                s_wait_card: begin
                    if (card_valid) begin
                        state      <= s_settle;
                        settle_cnt <= 1'b0;
                        if (deal_cnt < 3'd4) begin
                            deal_cnt <= deal_cnt + 3'd1;
                        end
                    end
                end
                // totals are valid in the second settle cycle.
                s_settle: begin
                    if (!settle_cnt) begin
                        settle_cnt <= 1'b1;
                    end else if (deal_cnt < 3'd4) begin
                        state     <= s_deal;
                        to_dealer <= deal_cnt[0];
                    end else if (dealer_phase) begin
                        state <= s_dealer;
                    end else if (player_bust) begin
                        state <= s_result;
                    end else if (player_count >= `BJ_HAND_SLOTS) begin
                        dealer_phase <= 1'b1;
                        state        <= s_dealer;
                    end else begin
                        state <= s_player;
                    end
                end
                s_player: begin
                    if (hit) begin
                        to_dealer <= 1'b0;
                        state     <= s_deal;
                    end else if (stand) begin
                        dealer_phase <= 1'b1;
                        state        <= s_dealer;
                    end
                end
                s_dealer: begin
                    if (dealer_draws) begin
                        to_dealer <= 1'b1;
                        state     <= s_deal;
                    end else begin
                        state <= s_result;
                    end
                end
                s_result: begin
                    done    <= 1'b1;
                    outcome <= verdict;
                    state   <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// File: hdl/blackjack_table.sv
`timescale 1ns/1ps

module blackjack_table (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    hit,
    input  logic                    stand,
    output logic                    card_valid,
    output blackjack_pkg::card_t    card_rank,
    output logic                    card_to_dealer,
    output blackjack_pkg::total_t   player_total,
    output blackjack_pkg::total_t   dealer_total,
    output logic                    player_turn,
    output logic                    done,
    output blackjack_pkg::outcome_t outcome
);

    logic                  draw;
    logic                  clear;
    blackjack_pkg::hand_t  player_cards;
    blackjack_pkg::hand_t  dealer_cards;
    blackjack_pkg::count_t player_count;
    blackjack_pkg::count_t dealer_count;

    card_shoe shoe (
        .clk        (clk),
        .rst        (rst),
        .draw       (draw),
        .card_valid (card_valid),
        .card_rank  (card_rank)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hands steered by card_to_dealer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    hand_register player_hand (
        .clk    (clk),
        .rst    (rst),
        .clear  (clear),
        .append (card_valid && !card_to_dealer),
        .card   (card_rank),
        .cards  (player_cards),
        .count  (player_count)
    );

    hand_register dealer_hand (
        .clk    (clk),
        .rst    (rst),
        .clear  (clear),
        .append (card_valid && card_to_dealer),
        .card   (card_rank),
        .cards  (dealer_cards),
        .count  (dealer_count)
    );

    calculate_card valuation (
        .clk                 (clk),
        .rst                 (rst),
        .player_cards        (player_cards),
        .dealer_cards        (dealer_cards),
        .total_players_value (player_total),
        .total_dealer_value  (dealer_total)
    );

    game_controller controller (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .hit            (hit),
        .stand          (stand),
        .card_valid     (card_valid),
        .player_total   (player_total),
        .dealer_total   (dealer_total),
        .player_count   (player_count),
        .dealer_count   (dealer_count),
        .draw           (draw),
        .clear          (clear),
        .card_to_dealer (card_to_dealer),
        .player_turn    (player_turn),
        .done           (done),
        .outcome        (outcome)
    );

endmodule

// File: verification/blackjack_properties.sv
`timescale 1ns/1ps

module blackjack_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    card_valid,
    input logic                    player_turn,
    input logic                    done,
    input blackjack_pkg::outcome_t outcome
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // player turn exclusions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the result only comes once the turn is over.
    done_outside_turn: assert property (@(posedge clk) disable iff (rst)
        !(done && player_turn))
        else $error("done pulsed while player_turn was high");

    // no draw is pending while the player decides.
    no_card_in_turn: assert property (@(posedge clk) disable iff (rst)
        !(card_valid && player_turn))
        else $error("card_valid seen while player_turn was high");

    // outcome was cleared by start and is set only at the result.
    no_outcome_in_turn: assert property (@(posedge clk) disable iff (rst)
        player_turn |-> (outcome == blackjack_pkg::none))
        else $error("outcome not none while player_turn was high");

endmodule

// File: verification/blackjack_tb.sv
`timescale 1ns/1ps

`include "blackjack_params.svh"

module blackjack_tb;

    localparam int HANDS = 60;
    // 18 cards with a long shoe wait each, plus the idle gap and settle cycles.
    localparam int HAND_CYCLES = 18 * 24 + 40;

    logic                    clk;
    logic                    rst;
    logic                    start;
    logic                    hit;
    logic                    stand;
    logic                    card_valid;
    blackjack_pkg::card_t    card_rank;
    logic                    card_to_dealer;
    blackjack_pkg::total_t   player_total;
    blackjack_pkg::total_t   dealer_total;
    logic                    player_turn;
    logic                    done;
    blackjack_pkg::outcome_t outcome;

    logic [15:0] rng;
    int          p_cards[$];
    int          d_cards[$];
    int          errors;
    int          hands_done;
    int          cards_seen;

    blackjack_table DUT (.*);

    bind blackjack_table blackjack_properties props (
        .clk         (clk),
        .rst         (rst),
        .card_valid  (card_valid),
        .player_turn (player_turn),
        .done        (done),
        .outcome     (outcome)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // fibonacci form with taps at 16, 14, 13 and 11 and one shift per bit.
    function automatic int take_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            rng   = {rng[14:0], rng[15] ^ rng[13] ^ rng[12] ^ rng[10]};
            value = (value << 1) | int'(rng[0]);
        end
        return value;
    endfunction

    // ace is 11 unless that would pass the bust limit.
    function automatic int hand_score(input int ranks[$]);
        int total;
        total = 0;
        foreach (ranks[i]) begin
            if (ranks[i] == 1)
                total += (total + 11 <= `BJ_BUST_LIMIT) ? 11 : 1;
            else if (ranks[i] >= 10)
                total += 10;
            else
                total += ranks[i];
        end
        return total;
    endfunction

    task automatic mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("FAIL %0t %s expected %0d got %0d", $time, name, expected, actual);
    endtask

    task automatic complain(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        #((HANDS * HAND_CYCLES + 10) * 10);
        $display("watchdog expired after %0d of %0d hands", hands_done, HANDS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int                      idle_wait;
        int                      pt;
        int                      dt;
        int                      pick;
        int                      exp_side;
        int                      deal_idx;
        int                      p_hist[2];
        int                      d_hist[2];
        logic                    clear_due;
        logic                    in_hand;
        logic                    stood;
        logic                    hit_due;
        blackjack_pkg::outcome_t exp_outcome;

        rng         = 16'd87;
        errors      = 0;
        hands_done  = 0;
        cards_seen  = 0;
        start       = 1'b0;
        hit         = 1'b0;
        stand       = 1'b0;
        rst         = 1'b1;
        p_hist[0]   = 0;
        p_hist[1]   = 0;
        d_hist[0]   = 0;
        d_hist[1]   = 0;
        deal_idx    = 0;
        clear_due   = 1'b0;
        in_hand     = 1'b0;
        stood       = 1'b0;
        hit_due     = 1'b0;
        exp_outcome = blackjack_pkg::none;
        idle_wait   = take_bits(3);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (hands_done < HANDS) begin
            @(negedge clk);
            start = 1'b0;
            hit   = 1'b0;
            stand = 1'b0;
            // hands are emptied one cycle after start is taken.
            if (clear_due) begin
                p_cards.delete();
                d_cards.delete();
                exp_outcome = blackjack_pkg::none;
                clear_due   = 1'b0;
            end
            if (int'(player_total) != p_hist[1])
                mismatch("player_total", p_hist[1], int'(player_total));
            if (int'(dealer_total) != d_hist[1])
                mismatch("dealer_total", d_hist[1], int'(dealer_total));
            pt = hand_score(p_cards);
            dt = hand_score(d_cards);

            if (card_valid) begin
                cards_seen++;
                exp_side = (deal_idx < 4) ? deal_idx % 2 : int'(stood);
                if (card_rank == 4'd0 || card_rank > 4'd13)
                    $display("FAIL %0t card_rank expected 1..13 got %0d", $time, card_rank);
                if (card_rank == 4'd0 || card_rank > 4'd13)
                    errors++;
                if (!in_hand || !(deal_idx < 4 || hit_due ||
                        (stood && dt < `BJ_DEALER_STAND && d_cards.size() < `BJ_HAND_SLOTS)))
                    complain("a card was dealt when none was due");
                else if (int'(card_to_dealer) != exp_side)
                    mismatch("card_to_dealer", exp_side, int'(card_to_dealer));
                if (exp_side == 1)
                    d_cards.push_back(int'(card_rank));
                else
                    p_cards.push_back(int'(card_rank));
                deal_idx++;
                hit_due = 1'b0;
                pt = hand_score(p_cards);
                dt = hand_score(d_cards);
                // a full player hand stands by itself.
                if (exp_side == 0 && p_cards.size() == `BJ_HAND_SLOTS && pt <= `BJ_BUST_LIMIT)
                    stood = 1'b1;
            end
            p_hist[1] = p_hist[0];
            p_hist[0] = pt;
            d_hist[1] = d_hist[0];
            d_hist[0] = dt;

            if (done) begin
                if (!in_hand || !(stood || pt > `BJ_BUST_LIMIT))
                    complain("done pulsed before the hand was over");
                if (stood && pt <= `BJ_BUST_LIMIT && dt < `BJ_DEALER_STAND &&
                        d_cards.size() < `BJ_HAND_SLOTS)
                    complain("dealer stopped drawing below the stand limit");
                if (pt > `BJ_BUST_LIMIT)
                    exp_outcome = blackjack_pkg::dealer_win;
                else if (dt > `BJ_BUST_LIMIT || pt > dt)
                    exp_outcome = blackjack_pkg::player_win;
                else if (pt < dt)
                    exp_outcome = blackjack_pkg::dealer_win;
                else
                    exp_outcome = blackjack_pkg::push;
                in_hand   = 1'b0;
                idle_wait = take_bits(3);
                hands_done++;
            end
            if (outcome != exp_outcome)
                mismatch("outcome", int'(exp_outcome), int'(outcome));

            if (player_turn) begin
                if (!in_hand || deal_idx < 4 || stood || hit_due || pt > `BJ_BUST_LIMIT)
                    complain("player_turn high when no decision was due");
                else if (take_bits(2) != 0) begin
                    pick = take_bits(3);
                    // mostly hit below 15, mostly stand above.
                    if ((pt < 15 && pick != 0) || (pt >= 15 && pick < 2)) begin
                        hit     = 1'b1;
                        hit_due = 1'b1;
                    end else begin
                        stand = 1'b1;
                        stood = 1'b1;
                    end
                end
            end else begin
                pick = take_bits(4);
                if (pick == 0)
                    hit = 1'b1;
                else if (pick == 1)
                    stand = 1'b1;
                else if (pick == 2 && in_hand)
                    start = 1'b1;
                if (!in_hand && hands_done < HANDS) begin
                    if (idle_wait == 0) begin
                        start     = 1'b1;
                        in_hand   = 1'b1;
                        clear_due = 1'b1;
                        deal_idx  = 0;
                        stood     = 1'b0;
                        hit_due   = 1'b0;
                    end else begin
                        idle_wait--;
                    end
                end
            end
        end

        $display("hands %0d, cards %0d, errors %0d", hands_done, cards_seen, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+hdl
hdl/blackjack_pkg.sv
hdl/card_shoe.sv
hdl/hand_register.sv
hdl/calculate_card.sv
hdl/game_controller.sv
hdl/blackjack_table.sv
verification/blackjack_properties.sv
verification/blackjack_tb.sv

// File: Makefile
TOP = blackjack_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
